/* hdl/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // Buffer depths
    localparam int ROB_ENTRIES = 8;
    localparam int RS_ENTRIES  = 4;

    typedef logic [31:0]                    word_t;
    typedef logic [4:0]                     reg_idx_t;
    typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_tag_t;
    typedef logic [3:0]                     alu_op_t;

    // Encoded as {funct7[5], funct3}
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SRA  = 4'b1101;

    // RV32I integer result, shifts take the low 5 bits of b
    function automatic word_t alu_compute(
        input alu_op_t op,
        input word_t   a,
        input word_t   b
    );
        word_t res;
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLL:  res = a << b[4:0];
            ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: res = {31'b0, a < b};
            ALU_XOR:  res = a ^ b;
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = word_t'($signed(a) >>> b[4:0]);
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            default:  res = '0;
        endcase
        return res;
    endfunction

endpackage : ooo_pkg

`default_nettype wire

/* hdl/dispatch_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One renamed operation on its way to the station and the ROB
interface dispatch_if;
    import ooo_pkg::*;

    logic     valid;
    alu_op_t  op;
    reg_idx_t rd;
    rob_tag_t tag;

    // Ready flag set means v holds the operand, else q names the producer
    word_t    vj;
    rob_tag_t qj;
    logic     rj;
    word_t    vk;
    rob_tag_t qk;
    logic     rk;

    modport src (output valid, op, rd, tag, vj, qj, rj, vk, qk, rk);
    modport rs  (input valid, op, tag, vj, qj, rj, vk, qk, rk);
    modport rob (input valid, rd, tag);

endinterface : dispatch_if

`default_nettype wire

/* hdl/rename_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_dispatch (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              issue_valid_i,
    input  ooo_pkg::alu_op_t  issue_op_i,
    input  ooo_pkg::reg_idx_t issue_rd_i,
    input  ooo_pkg::reg_idx_t issue_rs1_i,
    input  ooo_pkg::reg_idx_t issue_rs2_i,
    input  ooo_pkg::word_t    issue_imm_i,
    input  logic              issue_use_imm_i,
    input  logic              rob_full_i,
    input  logic              rs_full_i,
    input  ooo_pkg::rob_tag_t alloc_tag_i,
    output ooo_pkg::rob_tag_t lookup1_tag_o,
    output ooo_pkg::rob_tag_t lookup2_tag_o,
    input  logic              lookup1_done_i,
    input  logic              lookup2_done_i,
    input  ooo_pkg::word_t    lookup1_value_i,
    input  ooo_pkg::word_t    lookup2_value_i,
    input  logic              cdb_valid_i,
    input  ooo_pkg::rob_tag_t cdb_tag_i,
    input  ooo_pkg::word_t    cdb_value_i,
    input  logic              commit_valid_i,
    input  ooo_pkg::rob_tag_t commit_tag_i,
    input  ooo_pkg::reg_idx_t commit_rd_i,
    input  ooo_pkg::word_t    commit_value_i,
    output logic              full_o,
    dispatch_if.src           disp
);
    import ooo_pkg::*;

    // Architectural registers with their rename state
    word_t    regs_q [32];
    logic     busy_q [32];
    rob_tag_t pend_q [32];

    logic     accept;
    logic     rename_rd;
    word_t    vj;
    word_t    vk;
    rob_tag_t qj;
    rob_tag_t qk;
    logic     rj;
    logic     rk;

    // Register file first, then finished ROB entry, then live CDB
    function automatic void resolve(
        input  logic     busy,
        input  word_t    reg_val,
        input  rob_tag_t pend,
        input  logic     rob_done,
        input  word_t    rob_val,
        input  logic     cdb_valid,
        input  rob_tag_t cdb_tag,
        input  word_t    cdb_value,
        output word_t    v,
        output rob_tag_t q,
        output logic     r
    );
        v = reg_val;
        q = pend;
        r = 1'b1;
        if (busy) begin
            if (rob_done) begin
                v = rob_val;
            end else if (cdb_valid && cdb_tag == pend) begin
                v = cdb_value;
            end else begin
                r = 1'b0;
            end
        end
    endfunction

    assign full_o    = rob_full_i | rs_full_i;
    assign accept    = issue_valid_i && !full_o;
    // x0 never gets a tag
    assign rename_rd = accept && (issue_rd_i != '0);

    assign lookup1_tag_o = pend_q[issue_rs1_i];
    assign lookup2_tag_o = pend_q[issue_rs2_i];

    always_comb begin
        resolve(busy_q[issue_rs1_i], regs_q[issue_rs1_i], pend_q[issue_rs1_i],
                lookup1_done_i, lookup1_value_i, cdb_valid_i, cdb_tag_i, cdb_value_i,
                vj, qj, rj);
        resolve(busy_q[issue_rs2_i], regs_q[issue_rs2_i], pend_q[issue_rs2_i],
                lookup2_done_i, lookup2_value_i, cdb_valid_i, cdb_tag_i, cdb_value_i,
                vk, qk, rk);
        if (issue_use_imm_i) begin
            vk = issue_imm_i;
            qk = '0;
            rk = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
                busy_q[i] <= 1'b0;
                pend_q[i] <= '0;
            end
        end else begin
            if (commit_valid_i && commit_rd_i != '0) begin
                regs_q[commit_rd_i] <= commit_value_i;
                // Only the newest producer releases the register
                if (pend_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            // Placed last so a rename in the same cycle wins
            if (rename_rd) begin
                busy_q[issue_rd_i] <= 1'b1;
                pend_q[issue_rd_i] <= alloc_tag_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            disp.valid <= 1'b0;
        end else begin
            disp.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp.op  <= issue_op_i;
            disp.rd  <= issue_rd_i;
            disp.tag <= alloc_tag_i;
            disp.vj  <= vj;
            disp.qj  <= qj;
            disp.rj  <= rj;
            disp.vk  <= vk;
            disp.qk  <= qk;
            disp.rk  <= rk;
        end
    end

endmodule : rename_dispatch

`default_nettype wire

/* hdl/alu_rs.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_rs (
    input  logic              clk,
    input  logic              rst_n_i,
    dispatch_if.rs            disp,
    output logic              rs_full_o,
    output logic              cdb_valid_o,
    output ooo_pkg::rob_tag_t cdb_tag_o,
    output ooo_pkg::word_t    cdb_value_o
);
    import ooo_pkg::*;

    // Slot 0 holds the oldest entry, the queue stays compacted
    logic     valid_q [RS_ENTRIES];
    alu_op_t  op_q    [RS_ENTRIES];
    rob_tag_t tag_q   [RS_ENTRIES];
    word_t    vj_q    [RS_ENTRIES];
    rob_tag_t qj_q    [RS_ENTRIES];
    logic     rj_q    [RS_ENTRIES];
    word_t    vk_q    [RS_ENTRIES];
    rob_tag_t qk_q    [RS_ENTRIES];
    logic     rk_q    [RS_ENTRIES];

    logic     valid_d [RS_ENTRIES];
    alu_op_t  op_d    [RS_ENTRIES];
    rob_tag_t tag_d   [RS_ENTRIES];
    word_t    vj_d    [RS_ENTRIES];
    rob_tag_t qj_d    [RS_ENTRIES];
    logic     rj_d    [RS_ENTRIES];
    word_t    vk_d    [RS_ENTRIES];
    rob_tag_t qk_d    [RS_ENTRIES];
    logic     rk_d    [RS_ENTRIES];

    logic     sel_hit;
    logic     use_disp;
    int       sel_idx;
    int       occupied;
    alu_op_t  ex_op;
    rob_tag_t ex_tag;
    word_t    ex_a;
    word_t    ex_b;

    // Oldest ready entry, else a fully ready dispatch skips the queue
    always_comb begin
        sel_hit = 1'b0;
        sel_idx = 0;
        for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && rj_q[i] && rk_q[i]) begin
                sel_hit = 1'b1;
                sel_idx = i;
            end
        end
        use_disp = !sel_hit && disp.valid && disp.rj && disp.rk;
        ex_op    = use_disp ? disp.op  : op_q[sel_idx];
        ex_tag   = use_disp ? disp.tag : tag_q[sel_idx];
        ex_a     = use_disp ? disp.vj  : vj_q[sel_idx];
        ex_b     = use_disp ? disp.vk  : vk_q[sel_idx];
    end

    // Drop the issued entry, snoop the CDB and append the dispatch
    always_comb begin
        occupied = 0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            valid_d[i] = 1'b0;
            op_d[i]    = op_q[i];
            tag_d[i]   = tag_q[i];
            vj_d[i]    = vj_q[i];
            qj_d[i]    = qj_q[i];
            rj_d[i]    = rj_q[i];
            vk_d[i]    = vk_q[i];
            qk_d[i]    = qk_q[i];
            rk_d[i]    = rk_q[i];
        end
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (valid_q[i] && !(sel_hit && sel_idx == i)) begin
                valid_d[occupied] = 1'b1;
                op_d[occupied]    = op_q[i];
                tag_d[occupied]   = tag_q[i];
                qj_d[occupied]    = qj_q[i];
                qk_d[occupied]    = qk_q[i];
                // Value of a waiting operand is don't care until its flag rises
                vj_d[occupied]    = rj_q[i] ? vj_q[i] : cdb_value_o;
                vk_d[occupied]    = rk_q[i] ? vk_q[i] : cdb_value_o;
                rj_d[occupied]    = rj_q[i] || (cdb_valid_o && qj_q[i] == cdb_tag_o);
                rk_d[occupied]    = rk_q[i] || (cdb_valid_o && qk_q[i] == cdb_tag_o);
                occupied++;
            end
        end
        if (disp.valid && !use_disp) begin
            valid_d[occupied] = 1'b1;
            op_d[occupied]    = disp.op;
            tag_d[occupied]   = disp.tag;
            qj_d[occupied]    = disp.qj;
            qk_d[occupied]    = disp.qk;
            vj_d[occupied]    = disp.rj ? disp.vj : cdb_value_o;
            vk_d[occupied]    = disp.rk ? disp.vk : cdb_value_o;
            rj_d[occupied]    = disp.rj || (cdb_valid_o && disp.qj == cdb_tag_o);
            rk_d[occupied]    = disp.rk || (cdb_valid_o && disp.qk == cdb_tag_o);
            occupied++;
        end
    end

    // No room left for an issue accepted this cycle
    assign rs_full_o = (occupied >= RS_ENTRIES);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
            for (int i = 0; i < RS_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            cdb_valid_o <= sel_hit || use_disp;
            for (int i = 0; i < RS_ENTRIES; i++) begin
                valid_q[i] <= valid_d[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag_o   <= ex_tag;
        cdb_value_o <= alu_compute(ex_op, ex_a, ex_b);
        for (int i = 0; i < RS_ENTRIES; i++) begin
            op_q[i]  <= op_d[i];
            tag_q[i] <= tag_d[i];
            vj_q[i]  <= vj_d[i];
            qj_q[i]  <= qj_d[i];
            rj_q[i]  <= rj_d[i];
            vk_q[i]  <= vk_d[i];
            qk_q[i]  <= qk_d[i];
            rk_q[i]  <= rk_d[i];
        end
    end

endmodule : alu_rs

`default_nettype wire

/* hdl/ro_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module ro_buffer (
    input  logic              clk,
    input  logic              rst_n_i,
    dispatch_if.rob           disp,
    input  logic              cdb_valid_i,
    input  ooo_pkg::rob_tag_t cdb_tag_i,
    input  ooo_pkg::word_t    cdb_value_i,
    output ooo_pkg::rob_tag_t alloc_tag_o,
    output logic              rob_full_o,
    input  ooo_pkg::rob_tag_t lookup1_tag_i,
    input  ooo_pkg::rob_tag_t lookup2_tag_i,
    output logic              lookup1_done_o,
    output logic              lookup2_done_o,
    output ooo_pkg::word_t    lookup1_value_o,
    output ooo_pkg::word_t    lookup2_value_o,
    output logic              commit_valid_o,
    output ooo_pkg::rob_tag_t commit_tag_o,
    output ooo_pkg::reg_idx_t commit_rd_o,
    output ooo_pkg::word_t    commit_value_o
);
    import ooo_pkg::*;

    // Done bits stay set after retire until the slot is handed out again
    logic     done_q  [ROB_ENTRIES];
    reg_idx_t rd_q    [ROB_ENTRIES];
    word_t    value_q [ROB_ENTRIES];

    rob_tag_t                     head_q;
    rob_tag_t                     tail_q;
    logic [$clog2(ROB_ENTRIES):0] count_q;
    logic                         retire;

    assign retire = (count_q != '0) && done_q[head_q];

    // Skip the slot that the dispatch in flight is about to fill
    assign alloc_tag_o = tail_q + rob_tag_t'(disp.valid);
    assign rob_full_o  = (count_q + disp.valid) >= ROB_ENTRIES;

    // A slot being written this cycle still holds its old occupant
    assign lookup1_done_o  = done_q[lookup1_tag_i] && !(disp.valid && disp.tag == lookup1_tag_i);
    assign lookup2_done_o  = done_q[lookup2_tag_i] && !(disp.valid && disp.tag == lookup2_tag_i);
    assign lookup1_value_o = value_q[lookup1_tag_i];
    assign lookup2_value_o = value_q[lookup2_tag_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            commit_valid_o <= 1'b0;
            for (int i = 0; i < ROB_ENTRIES; i++) begin
                done_q[i] <= 1'b0;
            end
        end else begin
            commit_valid_o <= retire;
            if (disp.valid) begin
                tail_q            <= tail_q + 1'b1;
                done_q[disp.tag]  <= 1'b0;
            end
            if (cdb_valid_i) begin
                done_q[cdb_tag_i] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({disp.valid, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp.valid) begin
            rd_q[disp.tag] <= disp.rd;
        end
        if (cdb_valid_i) begin
            value_q[cdb_tag_i] <= cdb_value_i;
        end
        commit_tag_o   <= head_q;
        commit_rd_o    <= rd_q[head_q];
        commit_value_o <= value_q[head_q];
    end

endmodule : ro_buffer

`default_nettype wire

/* hdl/ooo_core.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_core (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              issue_valid_i,
    input  ooo_pkg::alu_op_t  issue_op_i,
    input  ooo_pkg::reg_idx_t issue_rd_i,
    input  ooo_pkg::reg_idx_t issue_rs1_i,
    input  ooo_pkg::reg_idx_t issue_rs2_i,
    input  ooo_pkg::word_t    issue_imm_i,
    input  logic              issue_use_imm_i,
    output logic              full_o,
    output logic              commit_valid_o,
    output ooo_pkg::rob_tag_t commit_tag_o,
    output ooo_pkg::reg_idx_t commit_rd_o,
    output ooo_pkg::word_t    commit_value_o
);
    import ooo_pkg::*;

    // Common data bus
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;

    // Rename to ROB
    rob_tag_t alloc_tag;
    logic     rob_full;
    logic     rs_full;
    rob_tag_t lookup1_tag;
    rob_tag_t lookup2_tag;
    logic     lookup1_done;
    logic     lookup2_done;
    word_t    lookup1_value;
    word_t    lookup2_value;

    dispatch_if disp ();

    rename_dispatch i_rename (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_op_i(issue_op_i),
        .issue_rd_i(issue_rd_i),
        .issue_rs1_i(issue_rs1_i),
        .issue_rs2_i(issue_rs2_i),
        .issue_imm_i(issue_imm_i),
        .issue_use_imm_i(issue_use_imm_i),
        .rob_full_i(rob_full),
        .rs_full_i(rs_full),
        .alloc_tag_i(alloc_tag),
        .lookup1_tag_o(lookup1_tag),
        .lookup2_tag_o(lookup2_tag),
        .lookup1_done_i(lookup1_done),
        .lookup2_done_i(lookup2_done),
        .lookup1_value_i(lookup1_value),
        .lookup2_value_i(lookup2_value),
        .cdb_valid_i(cdb_valid),
        .cdb_tag_i(cdb_tag),
        .cdb_value_i(cdb_value),
        .commit_valid_i(commit_valid_o),
        .commit_tag_i(commit_tag_o),
        .commit_rd_i(commit_rd_o),
        .commit_value_i(commit_value_o),
        .full_o(full_o),
        .disp(disp.src)
    );

    alu_rs i_alu_rs (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .disp(disp.rs),
        .rs_full_o(rs_full),
        .cdb_valid_o(cdb_valid),
        .cdb_tag_o(cdb_tag),
        .cdb_value_o(cdb_value)
    );

    ro_buffer i_rob (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .disp(disp.rob),
        .cdb_valid_i(cdb_valid),
        .cdb_tag_i(cdb_tag),
        .cdb_value_i(cdb_value),
        .alloc_tag_o(alloc_tag),
        .rob_full_o(rob_full),
        .lookup1_tag_i(lookup1_tag),
        .lookup2_tag_i(lookup2_tag),
        .lookup1_done_o(lookup1_done),
        .lookup2_done_o(lookup2_done),
        .lookup1_value_o(lookup1_value),
        .lookup2_value_o(lookup2_value),
        .commit_valid_o(commit_valid_o),
        .commit_tag_o(commit_tag_o),
        .commit_rd_o(commit_rd_o),
        .commit_value_o(commit_value_o)
    );

endmodule : ooo_core

`default_nettype wire

/* verification/ooo_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int RANDOM_OPS   = 200;
    // Directed tests issue 32, 23, 19, 5 and 21 instructions
    localparam int TOTAL_ISSUES = 100 + RANDOM_OPS;
    localparam int CYCLE_LIMIT  = 20 * TOTAL_ISSUES + 200;
    localparam int DRAIN_LIMIT  = 100;

    logic     clk;
    logic     rst_n;
    logic     issue_valid;
    alu_op_t  issue_op;
    reg_idx_t issue_rd;
    reg_idx_t issue_rs1;
    reg_idx_t issue_rs2;
    word_t    issue_imm;
    logic     issue_use_imm;
    logic     full;
    logic     commit_valid;
    rob_tag_t commit_tag;
    reg_idx_t commit_rd;
    word_t    commit_value;

    // In-order reference model and the commits it still expects
    word_t    ref_regs [32];
    word_t    exp_value_q [$];
    reg_idx_t exp_rd_q [$];
    rob_tag_t exp_tag_q [$];
    int       issue_count = 0;

    int       error_count = 0;
    int       tests_ok    = 0;
    int       tests_bad   = 0;
    int       cycle_count = 0;
    logic     full_seen   = 1'b0;
    int       seed        = 59;

    alu_op_t  op_table [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};

    ooo_core i_dut (
        .clk(clk),
        .rst_n_i(rst_n),
        .issue_valid_i(issue_valid),
        .issue_op_i(issue_op),
        .issue_rd_i(issue_rd),
        .issue_rs1_i(issue_rs1),
        .issue_rs2_i(issue_rs2),
        .issue_imm_i(issue_imm),
        .issue_use_imm_i(issue_use_imm),
        .full_o(full),
        .commit_valid_o(commit_valid),
        .commit_tag_o(commit_tag),
        .commit_rd_o(commit_rd),
        .commit_value_o(commit_value)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got x%0d, expected x%0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n && full) begin
            full_seen = 1'b1;
        end
        if (rst_n && commit_valid) begin
            if (exp_value_q.size() == 0) begin
                $display("Unexpected commit at %0t: tag %0d retired with nothing outstanding",
                         $time, commit_tag);
                error_count++;
            end else begin
                compare_tag("commit_tag_o", commit_tag, exp_tag_q.pop_front());
                compare_reg("commit_rd_o", commit_rd, exp_rd_q.pop_front());
                compare_word("commit_value_o", commit_value, exp_value_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the core stopped making progress", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    task automatic drive_issue(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                               input reg_idx_t rs2, input word_t imm, input logic use_imm);
        word_t a;
        word_t b;
        word_t res;
        // Hold off while the core has no room
        while (full) begin
            @(posedge clk);
            #1;
        end
        a   = ref_regs[rs1];
        b   = use_imm ? imm : ref_regs[rs2];
        res = alu_compute(op, a, b);
        issue_valid   = 1'b1;
        issue_op      = op;
        issue_rd      = rd;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_imm     = imm;
        issue_use_imm = use_imm;
        exp_value_q.push_back(res);
        exp_rd_q.push_back(rd);
        exp_tag_q.push_back(rob_tag_t'(issue_count % ROB_ENTRIES));
        if (rd != '0) begin
            ref_regs[rd] = res;
        end
        issue_count++;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic imm_op(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                          input word_t imm);
        drive_issue(op, rd, rs1, '0, imm, 1'b1);
    endtask

    task automatic reg_op(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                          input reg_idx_t rs2);
        drive_issue(op, rd, rs1, rs2, '0, 1'b0);
    endtask

    task automatic drain_commits(input string name);
        int cycles;
        cycles = 0;
        while (exp_value_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_value_q.size() != 0) begin
            $display("Missing commits after %s: %0d instructions never retired",
                     name, exp_value_q.size());
            error_count++;
            exp_value_q.delete();
            exp_rd_q.delete();
            exp_tag_q.delete();
        end
        #1;
    endtask

    task automatic report_result(input string name, input int start_errors);
        drain_commits(name);
        if (error_count == start_errors) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: FAILED with %0d errors", name, error_count - start_errors);
            tests_bad++;
        end
    endtask

    task automatic reset_state();
        int start_errors;
        start_errors = error_count;
        compare_bit("full_o", full, 1'b0);
        compare_bit("commit_valid_o", commit_valid, 1'b0);
        for (int r = 0; r < 32; r++) begin
            imm_op(ALU_ADD, reg_idx_t'(r), reg_idx_t'(r), '0);
        end
        report_result("reset_state", start_errors);
    endtask

    task automatic independent_ops();
        int start_errors;
        start_errors = error_count;
        imm_op(ALU_ADD, 1, 0, 32'h8000_0F0F);
        imm_op(ALU_ADD, 2, 0, 32'h0000_0007);
        imm_op(ALU_ADD, 3, 0, 32'hFFFF_FFF0);
        // Low 5 bits of the immediate shift by 19
        for (int i = 0; i < 10; i++) begin
            imm_op(op_table[i], reg_idx_t'(10 + i), 1, 32'h0000_0F33);
        end
        for (int i = 0; i < 10; i++) begin
            reg_op(op_table[i], reg_idx_t'(20 + i), 3, 2);
        end
        report_result("independent_ops", start_errors);
    endtask

    task automatic dependency_chains();
        int start_errors;
        start_errors = error_count;
        imm_op(ALU_ADD, 5, 0, 32'd1);
        repeat (8) begin
            reg_op(ALU_ADD, 5, 5, 5);
        end
        // Later readers of x7 hit the station wait, the CDB, then the ROB
        imm_op(ALU_ADD, 7, 0, 32'd9);
        for (int k = 1; k <= 6; k++) begin
            imm_op(ALU_ADD, reg_idx_t'(7 + k), 7, word_t'(k));
        end
        reg_op(ALU_SUB, 14, 13, 5);
        drain_commits("dependency_chains");
        imm_op(ALU_XOR, 15, 5, 32'h0000_0055);
        reg_op(ALU_AND, 16, 14, 15);
        report_result("dependency_chains", start_errors);
    endtask

    task automatic zero_register();
        int start_errors;
        start_errors = error_count;
        imm_op(ALU_ADD, 0, 0, 32'd123);
        reg_op(ALU_ADD, 0, 1, 2);
        imm_op(ALU_ADD, 4, 0, '0);
        reg_op(ALU_OR, 4, 0, 0);
        drain_commits("zero_register");
        reg_op(ALU_ADD, 17, 0, 0);
        report_result("zero_register", start_errors);
    endtask

    task automatic core_fill();
        int start_errors;
        start_errors = error_count;
        full_seen    = 1'b0;
        // A serial chain executes slower than one issue per cycle
        repeat (20) begin
            imm_op(ALU_ADD, 5, 5, 32'd1);
        end
        reg_op(ALU_XOR, 6, 5, 5);
        if (!full_seen) begin
            $display("The core never reported full while a long chain was issued");
            error_count++;
        end
        report_result("core_fill", start_errors);
    endtask

    task automatic random_mix();
        int       start_errors;
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     use_imm;
        start_errors = error_count;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            op      = op_table[$unsigned($random(seed)) % 10];
            // Four registers keep the dependencies dense
            rd      = reg_idx_t'($random(seed) & 3);
            rs1     = reg_idx_t'($random(seed) & 3);
            rs2     = reg_idx_t'($random(seed) & 3);
            imm     = $random(seed);
            use_imm = (($random(seed) & 1) != 0);
            drive_issue(op, rd, rs1, rs2, imm, use_imm);
            if (($random(seed) & 7) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        report_result("random_mix", start_errors);
    endtask

    initial begin
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = ALU_ADD;
        issue_rd      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_imm     = '0;
        issue_use_imm = 1'b0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_state();
        independent_ops();
        dependency_chains();
        zero_register();
        core_fill();
        random_mix();

        $display("Summary: %0d ok, %0d bad, %0d errors, %0d instructions issued",
                 tests_ok, tests_bad, error_count, issue_count);
        if (error_count == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : ooo_core_tb

`default_nettype wire

/* tb.f */
hdl/ooo_pkg.sv
hdl/dispatch_if.sv
hdl/rename_dispatch.sv
hdl/alu_rs.sv
hdl/ro_buffer.sv
hdl/ooo_core.sv
verification/ooo_core_tb.sv
